/* logic/lb_pkg.sv */
// Local bus slave definitions
`default_nettype none

package lb_pkg;

	// --------------------------------------------------
	// bus transfer
	// --------------------------------------------------
	typedef struct packed {
		logic [23:0] addr;
		logic [31:0] wdata;
		logic        strobe;
		logic        rd;
	} lb_req_t;

	typedef logic [31:0] lb_resp_t;

	// read target, decoded in the first pipeline stage
	typedef enum logic [1:0] {REG_BANK, CFG_ROM, MIRROR, UNMAPPED} lb_region_t;

	// local page write registers, addr[4:0]
	typedef enum logic [4:0] {
		W_LED_USER  = 5'd1,
		W_LED1_DUTY = 5'd2,
		W_LED2_DUTY = 5'd3,
		W_FAULT_CLR = 5'd4,
		W_RX_HBANK  = 5'd5,
		W_MISC_CFG  = 5'd8
	} lb_wreg_t;

	typedef struct packed {
		logic       led_user;
		logic [7:0] led1_duty;
		logic [7:0] led2_duty;
		logic       rx_hbank;
		logic [7:0] misc;
	} lb_cfg_t;

	// --------------------------------------------------
	// address map and widths
	// --------------------------------------------------
	localparam logic [7:0]  LOCAL_PAGE  = 8'h05;
	localparam logic [23:0] ROM_BASE    = 24'h000800;
	localparam int          ROM_AW      = 6;
	localparam int          MIRROR_AW   = 5;
	localparam int          LED_CW      = 10;
	typedef logic [LED_CW-1:0] led_cnt_t;

	localparam logic [31:0] FILLER_WORD = 32'hdeadbeef;
	// identification string, four characters per word
	localparam logic [31:0] ID_WORD0    = "Hell";
	localparam logic [31:0] ID_WORD1    = "o wo";
	localparam logic [31:0] ID_WORD2    = "rld!";
	localparam logic [31:0] ID_WORD3    = "(::)";
	localparam logic [15:0] ROM_MAGIC   = 16'h800a;
	localparam logic [7:0]  MISC_RESET  = 8'h00;

endpackage

`default_nettype wire

/* logic/mirror_ram.sv */
// Write mirror memory
`default_nettype none

module mirror_ram (
	input  logic                        clk,
	input  logic                        we,
	input  logic [lb_pkg::MIRROR_AW-1:0] addr,
	input  logic [31:0]                 wdata,
	output logic [31:0]                 rdata
);

	logic [31:0] mem [2**lb_pkg::MIRROR_AW];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// registered read, lines up with stage 1
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* logic/config_rom.sv */
// Configuration descriptor ROM
`default_nettype none

module config_rom (
	input  logic                      clk,
	input  logic [lb_pkg::ROM_AW-1:0] index,
	output logic [15:0]               data
);

	// descriptor words, rest of the table is zero
	always_ff @(posedge clk) begin
		case (index)
			6'd0: data <= lb_pkg::ROM_MAGIC;
			// format version
			6'd1: data <= 16'h0001;
			// bus address width
			6'd2: data <= 16'h0018;
			// bus data width
			6'd3: data <= 16'h0020;
			default: data <= 16'h0000;
		endcase
	end

endmodule

`default_nettype wire

/* logic/led_blink_timer.sv */
// LED blink timer
`default_nettype none

module led_blink_timer (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] led1_duty,
	input  logic [7:0] led2_duty,
	output logic       led1,
	output logic       led2,
	output logic       tick
);

	lb_pkg::led_cnt_t cnt;

	// one blink period is 2**LED_CW cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			cnt  <= cnt + 1'b1;
			// high on the cycle after the all-ones count
			tick <= &cnt;
			// duty counts in steps of four cycles
			led1 <= cnt < lb_pkg::led_cnt_t'({led1_duty, 2'b00});
			led2 <= cnt < lb_pkg::led_cnt_t'({led2_duty, 2'b00});
		end
	end

endmodule

`default_nettype wire

/* logic/status_counters.sv */
// Fault, uptime and network status
`default_nettype none

module status_counters (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        xdomain_fault,
	input  logic        fault_clr,
	input  logic        tick,
	input  logic        tx_mac_done,
	input  logic [1:0]  rx_mac_buf_status,
	output logic [15:0] fault_count,
	output logic [31:0] uptime,
	output logic [2:0]  mac_status
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_count <= 16'h0000;
			uptime      <= 32'h0000_0000;
			mac_status  <= 3'b000;
		end else begin
			// clear wins over a fault in the same cycle
			if (fault_clr)
				fault_count <= 16'h0000;
			else if (xdomain_fault)
				fault_count <= fault_count + 1'b1;
			// one count per blink period
			if (tick)
				uptime <= uptime + 1'b1;
			mac_status <= {tx_mac_done, rx_mac_buf_status};
		end
	end

endmodule

`default_nettype wire

/* logic/lb_write_decode.sv */
// Local page write decode
`default_nettype none

module lb_write_decode (
	input  logic            clk,
	input  logic            arst_n,
	input  lb_pkg::lb_req_t req,
	output lb_pkg::lb_cfg_t cfg,
	output logic            mirror_we,
	output logic            fault_clr
);

	logic             local_write;
	lb_pkg::lb_wreg_t wreg;

	assign local_write = req.strobe & ~req.rd & (req.addr[23:16] == lb_pkg::LOCAL_PAGE);
	assign wreg        = lb_pkg::lb_wreg_t'(req.addr[4:0]);

	// every local write is copied to the mirror
	assign mirror_we = local_write;

	// --------------------------------------------------
	// configuration registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.led_user  <= 1'b0;
			cfg.led1_duty <= 8'h00;
			cfg.led2_duty <= 8'h00;
			cfg.rx_hbank  <= 1'b1;
			cfg.misc      <= lb_pkg::MISC_RESET;
		end else if (local_write) begin
			case (wreg)
				lb_pkg::W_LED_USER:  cfg.led_user  <= req.wdata[0];
				lb_pkg::W_LED1_DUTY: cfg.led1_duty <= req.wdata[7:0];
				lb_pkg::W_LED2_DUTY: cfg.led2_duty <= req.wdata[7:0];
				lb_pkg::W_RX_HBANK:  cfg.rx_hbank  <= req.wdata[0];
				lb_pkg::W_MISC_CFG:  cfg.misc      <= req.wdata[7:0];
				default: ;
			endcase
		end
	end

	// clear command, data ignored
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			fault_clr <= 1'b0;
		else
			fault_clr <= local_write && (wreg == lb_pkg::W_FAULT_CLR);
	end

	// host sends one clear command at a time
	assert property (@(posedge clk) disable iff (!arst_n) fault_clr |=> !fault_clr)
		else $error("fault clear pulse lasted two cycles");

endmodule

`default_nettype wire

/* logic/lb_read_mux.sv */
// Two-stage read pipeline
`default_nettype none

module lb_read_mux (
	input  logic              clk,
	input  logic              arst_n,
	input  lb_pkg::lb_req_t   req,
	input  logic [15:0]       fault_count,
	input  logic [31:0]       uptime,
	input  logic [2:0]        mac_status,
	input  logic [7:0]        misc_config,
	input  logic [15:0]       rom_data,
	input  logic [31:0]       mirror_data,
	output lb_pkg::lb_resp_t  rdata
);

	logic               do_rd;
	logic               rd_v;
	lb_pkg::lb_region_t region;
	lb_pkg::lb_region_t region_r;
	logic [31:0]        status_r;

	assign do_rd = req.strobe & req.rd;

	// rom window is xxx800..xxxfff of page 0, status bank at 0x00000x
	always_comb begin
		if (req.addr[23:11] == lb_pkg::ROM_BASE[23:11])
			region = lb_pkg::CFG_ROM;
		else if (req.addr[23:16] == 8'h00 && req.addr[15:4] == 12'h000)
			region = lb_pkg::REG_BANK;
		else if (req.addr[23:16] == lb_pkg::LOCAL_PAGE)
			region = lb_pkg::MIRROR;
		else
			region = lb_pkg::UNMAPPED;
	end

	// --------------------------------------------------
	// stage 1
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_v     <= 1'b0;
			region_r <= lb_pkg::UNMAPPED;
		end else begin
			rd_v <= do_rd;
			if (do_rd)
				region_r <= region;
		end
	end

	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (req.addr[3:0])
				4'h0: status_r <= lb_pkg::ID_WORD0;
				4'h1: status_r <= lb_pkg::ID_WORD1;
				4'h2: status_r <= lb_pkg::ID_WORD2;
				4'h3: status_r <= lb_pkg::ID_WORD3;
				4'h4: status_r <= 32'(fault_count);
				4'h5: status_r <= uptime;
				4'h6: status_r <= 32'(mac_status);
				4'h7: status_r <= 32'(misc_config);
				default: status_r <= lb_pkg::FILLER_WORD;
			endcase
		end
	end

	// --------------------------------------------------
	// stage 2
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else if (rd_v) begin
			case (region_r)
				lb_pkg::REG_BANK: rdata <= status_r;
				lb_pkg::CFG_ROM:  rdata <= {16'h0000, rom_data};
				lb_pkg::MIRROR:   rdata <= mirror_data;
				default:          rdata <= lb_pkg::FILLER_WORD;
			endcase
		end
	end

	// region decode needs a known address on every read strobe
	assert property (@(posedge clk) disable iff (!arst_n) do_rd |-> !$isunknown(req.addr))
		else $error("read strobe with an unknown address");

endmodule

`default_nettype wire

/* logic/lb_slave_top.sv */
// Local bus register slave
`default_nettype none

module lb_slave_top (
	input  logic             clk,
	input  logic             arst_n,
	input  lb_pkg::lb_req_t  req,
	input  logic             xdomain_fault,
	input  logic             tx_mac_done,
	input  logic [1:0]       rx_mac_buf_status,
	output lb_pkg::lb_resp_t rdata,
	output logic             led_user_mode,
	output logic             led1,
	output logic             led2,
	output logic             rx_mac_hbank,
	output logic [7:0]       misc_config
);

	lb_pkg::lb_cfg_t cfg;
	logic            mirror_we;
	logic            fault_clr;
	logic            tick;
	logic [31:0]     mirror_data;
	logic [15:0]     rom_data;
	logic [15:0]     fault_count;
	logic [31:0]     uptime;
	logic [2:0]      mac_status;

	// --------------------------------------------------
	// bus side
	// --------------------------------------------------
	lb_write_decode u_wr (.clk(clk), .arst_n(arst_n), .req(req), .cfg(cfg),
		.mirror_we(mirror_we), .fault_clr(fault_clr));

	mirror_ram u_mirror (.clk(clk), .we(mirror_we), .addr(req.addr[lb_pkg::MIRROR_AW-1:0]),
		.wdata(req.wdata), .rdata(mirror_data));

	config_rom u_rom (.clk(clk), .index(req.addr[lb_pkg::ROM_AW-1:0]), .data(rom_data));

	lb_read_mux u_rd (.clk(clk), .arst_n(arst_n), .req(req), .fault_count(fault_count),
		.uptime(uptime), .mac_status(mac_status), .misc_config(cfg.misc),
		.rom_data(rom_data), .mirror_data(mirror_data), .rdata(rdata));

	// --------------------------------------------------
	// LEDs and status
	// --------------------------------------------------
	led_blink_timer u_led (.clk(clk), .arst_n(arst_n), .led1_duty(cfg.led1_duty),
		.led2_duty(cfg.led2_duty), .led1(led1), .led2(led2), .tick(tick));

	status_counters u_stat (.clk(clk), .arst_n(arst_n), .xdomain_fault(xdomain_fault),
		.fault_clr(fault_clr), .tick(tick), .tx_mac_done(tx_mac_done),
		.rx_mac_buf_status(rx_mac_buf_status), .fault_count(fault_count),
		.uptime(uptime), .mac_status(mac_status));

	assign led_user_mode = cfg.led_user;
	assign rx_mac_hbank  = cfg.rx_hbank;
	assign misc_config   = cfg.misc;

endmodule

`default_nettype wire

/* bench/lb_slave_tb.sv */
// Local bus slave testbench
`default_nettype none

module lb_slave_tb;

	typedef struct packed {
		logic        wr;
		logic [23:0] addr;
		logic [31:0] wdata;
		logic [31:0] expv;
	} step_t;

	logic             clk = 1'b0;
	logic             arst_n;
	lb_pkg::lb_req_t  req;
	logic             xdomain_fault;
	logic             tx_mac_done;
	logic [1:0]       rx_mac_buf_status;
	lb_pkg::lb_resp_t rdata;
	logic             led_user_mode;
	logic             led1;
	logic             led2;
	logic             rx_mac_hbank;
	logic [7:0]       misc_config;

	integer      seed = 32'haba6_1e70;
	int          errors = 0;
	int          test_start = 0;
	int          tests_failed = 0;
	logic [31:0] rd_val;
	logic [31:0] first_val;
	logic [31:0] wr_data [32];
	int          cnt1;
	int          cnt2;
	int          n;
	int          duty [3] = '{0, 37, 255};

	// --------------------------------------------------
	// stimulus table, reads carry the expected word
	// --------------------------------------------------
	step_t steps [0:14] = '{
		'{1'b0, 24'h000000, 32'h0, "Hell"},
		'{1'b0, 24'h000001, 32'h0, "o wo"},
		'{1'b0, 24'h000002, 32'h0, "rld!"},
		'{1'b0, 24'h000003, 32'h0, "(::)"},
		'{1'b0, 24'h030000, 32'h0, 32'hdeadbeef},
		'{1'b0, 24'h000008, 32'h0, 32'hdeadbeef},
		'{1'b0, 24'h000800, 32'h0, 32'h0000800a},
		'{1'b0, 24'h000801, 32'h0, 32'h00000001},
		'{1'b0, 24'h000802, 32'h0, 32'h00000018},
		'{1'b0, 24'h000803, 32'h0, 32'h00000020},
		'{1'b0, 24'h00080a, 32'h0, 32'h00000000},
		// misc byte, then read back at status offset 7
		'{1'b1, 24'h050008, 32'h0000005a, 32'h0},
		'{1'b0, 24'h000007, 32'h0, 32'h0000005a},
		'{1'b1, 24'h050005, 32'h00000000, 32'h0},
		'{1'b0, 24'h050005, 32'h0, 32'h00000000}
	};

	lb_slave_top dut (.clk(clk), .arst_n(arst_n), .req(req), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_buf_status(rx_mac_buf_status), .rdata(rdata),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2),
		.rx_mac_hbank(rx_mac_hbank), .misc_config(misc_config));

	always #50 clk = ~clk;

	task check(input string name, input logic [31:0] got, input logic [31:0] expv);
		if (got !== expv) begin
			$display("** Error %s: got %h, expected %h", name, got, expv);
			errors++;
		end
	endtask

	task wait_cycles(input int cycles);
		for (int i = 0; i < cycles; i++)
			@(negedge clk);
	endtask

	// all bus tasks start and end on a falling edge
	task bus_write(input logic [23:0] addr, input logic [31:0] data);
		req.addr   = addr;
		req.wdata  = data;
		req.rd     = 1'b0;
		req.strobe = 1'b1;
		@(negedge clk);
		req.strobe = 1'b0;
	endtask

	// data is valid after the second rising edge following the strobe edge
	task bus_read(input logic [23:0] addr, output logic [31:0] data);
		req.addr   = addr;
		req.rd     = 1'b1;
		req.strobe = 1'b1;
		@(negedge clk);
		req.strobe = 1'b0;
		req.rd     = 1'b0;
		wait_cycles(2);
		data = rdata;
	endtask

	task run_steps(input int first, input int last);
		logic [31:0] got;
		for (int i = first; i <= last; i++) begin
			if (steps[i].wr) begin
				bus_write(steps[i].addr, steps[i].wdata);
			end else begin
				bus_read(steps[i].addr, got);
				check($sformatf("rdata at %06h", steps[i].addr), got, steps[i].expv);
			end
		end
	endtask

	task finish_test(input string name);
		if (errors == test_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d mismatches", name, errors - test_start);
			tests_failed++;
		end
		test_start = errors;
	endtask

	initial begin
		arst_n            = 1'b0;
		req               = '0;
		xdomain_fault     = 1'b0;
		tx_mac_done       = 1'b0;
		rx_mac_buf_status = 2'b00;
		wait_cycles(2);
		arst_n = 1'b1;
		@(negedge clk);

		run_steps(0, 5);
		finish_test("identification and filler");
		run_steps(6, 10);
		finish_test("configuration rom");

		// --------------------------------------------------
		// local writes and mirror
		// --------------------------------------------------
		check("misc_config", 32'(misc_config), 32'h00);
		check("rx_mac_hbank", 32'(rx_mac_hbank), 32'h1);
		check("led_user_mode", 32'(led_user_mode), 32'h0);
		check("led1", 32'(led1), 32'h0);
		check("led2", 32'(led2), 32'h0);
		bus_read(24'h000007, rd_val);
		check("rdata at 000007", rd_val, 32'h0);
		for (int i = 0; i < 32; i++) begin
			wr_data[i] = $random(seed);
			bus_write(24'h050000 | 24'(i), wr_data[i]);
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(24'h050000 | 24'(i), rd_val);
			check($sformatf("mirror word %0d", i), rd_val, wr_data[i]);
		end
		// user LED both ways
		bus_write(24'h050001, 32'h1);
		check("led_user_mode", 32'(led_user_mode), 32'h1);
		bus_write(24'h050001, 32'h0);
		check("led_user_mode", 32'(led_user_mode), 32'h0);
		run_steps(11, 14);
		n = 0;
		while ((misc_config !== 8'h5a || rx_mac_hbank !== 1'b0) && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (n == 16) begin
			$display("timed out waiting for the configuration ports to update");
			errors++;
		end
		check("misc_config", 32'(misc_config), 32'h5a);
		check("rx_mac_hbank", 32'(rx_mac_hbank), 32'h0);
		finish_test("local writes and mirror");

		// --------------------------------------------------
		// fault counter and network status
		// --------------------------------------------------
		tx_mac_done       = 1'b1;
		rx_mac_buf_status = 2'b10;
		xdomain_fault     = 1'b1;
		wait_cycles(13);
		xdomain_fault = 1'b0;
		bus_read(24'h000004, rd_val);
		check("fault_count", rd_val, 32'd13);
		bus_write(24'h050004, 32'h0);
		// clear lands one edge after the write
		wait_cycles(1);
		bus_read(24'h000004, rd_val);
		check("fault_count", rd_val, 32'd0);
		bus_read(24'h000006, rd_val);
		check("mac_status", rd_val, 32'h6);
		finish_test("fault counter");

		// --------------------------------------------------
		// LED duty over one full blink period
		// --------------------------------------------------
		for (int d = 0; d < 3; d++) begin
			bus_write(24'h050002, 32'(duty[d]));
			bus_write(24'h050003, 32'(255 - duty[d]));
			wait_cycles(1024);
			cnt1 = 0;
			cnt2 = 0;
			for (int c = 0; c < 1024; c++) begin
				@(negedge clk);
				cnt1 += int'(led1);
				cnt2 += int'(led2);
			end
			check("led1 high cycles", 32'(cnt1), 32'(duty[d] * 4));
			check("led2 high cycles", 32'(cnt2), 32'((255 - duty[d]) * 4));
		end
		finish_test("led duty");

		// reads issued exactly 2048 cycles apart
		bus_read(24'h000005, first_val);
		wait_cycles(2045);
		bus_read(24'h000005, rd_val);
		check("uptime difference", rd_val - first_val, 32'd2);
		finish_test("uptime");

		$display("tests run 6, tests failed %0d, mismatches %0d", tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* marble_lb.f */
logic/lb_pkg.sv
logic/mirror_ram.sv
logic/config_rom.sv
logic/led_blink_timer.sv
logic/status_counters.sv
logic/lb_write_decode.sv
logic/lb_read_mux.sv
logic/lb_slave_top.sv
bench/lb_slave_tb.sv

/* Makefile */
TOP := lb_slave_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f marble_lb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f marble_lb.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
